//--- Makefile
TOP := tb_i2c_route

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- common/i2c_route_pkg.sv
`include "i2c_route_settings.svh"

package i2c_route_pkg;

	// ------------------------------------------------------------------------
	// Route choice of one master
	// ------------------------------------------------------------------------
	typedef enum logic [`I2C_ROUTE_W-1:0] {
		ROUTE_GPIO = 2'd0,	// GPIO pins
		ROUTE_CC   = 2'd1,	// CC1/CC2 pins, swappable
		ROUTE_DPDM = 2'd2,	// DP/DM pins, swappable
		ROUTE_OFF  = 2'd3	// Master disconnected
	} route_e;

	// Six-bit route register
	typedef struct packed {
		logic	dpdm_swap;	// Bit 5
		logic	cc_swap;	// Bit 4
		route_e	mcu_route;	// Bits 3:2
		route_e	slv_route;	// Bits 1:0
	} route_cfg_t;

	// ------------------------------------------------------------------------
	// Open-drain levels, 1 is released and 0 is pulled low
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic	sda;
		logic	scl;
	} pin_pair_t;

	// Routing of one pin pair
	typedef struct packed {
		logic	slv;	// Slave engine on this pair
		logic	mcu;	// MCU I2C unit on this pair
		logic	swap;	// SDA/SCL exchanged on the pins
	} port_sel_t;

	typedef pin_pair_t pad_bus_t [`I2C_NUM_PORTS];

endpackage

//--- common/i2c_route_settings.svh
`ifndef I2C_ROUTE_SETTINGS_SVH
`define I2C_ROUTE_SETTINGS_SVH

// Pin pairs shared by the slave engine and the MCU I2C unit
`define I2C_NUM_PORTS	3

// Port indices match the route codes
`define I2C_PORT_GPIO	0
`define I2C_PORT_CC	1
`define I2C_PORT_DPDM	2

// Width of one route field in the route register
`define I2C_ROUTE_W	2

`endif

//--- logic/i2c_in_merge.sv
`include "i2c_route_settings.svh"

module i2c_in_merge (
	input  i2c_route_pkg::pad_bus_t	i_slv_in,	// Slave view, per port
	input  i2c_route_pkg::pad_bus_t	i_mcu_in,	// MCU view, per port
	output i2c_route_pkg::pin_pair_t	o_slv_in,	// To slave engine
	output i2c_route_pkg::pin_pair_t	o_mcu_in	// To MCU I2C unit
);

	i2c_route_pkg::pin_pair_t slv_and;
	i2c_route_pkg::pin_pair_t mcu_and;

	// ------------------------------------------------------------------------
	// Wired-AND over all ports
	// ------------------------------------------------------------------------
	always_comb begin
		slv_and = 2'b11;	// Released when nothing routed
		mcu_and = 2'b11;
		for (int p = 0; p < `I2C_NUM_PORTS; p++) begin
			slv_and = slv_and & i_slv_in[p];
			mcu_and = mcu_and & i_mcu_in[p];
		end
	end

	assign o_slv_in = slv_and;
	assign o_mcu_in = mcu_and;

endmodule // i2c_in_merge

//--- logic/i2c_pad_port.sv
module i2c_pad_port (
	input  i2c_route_pkg::port_sel_t	i_sel,		// Masters routed here
	input  logic				i_stretch,	// Slave SCL hold
	input  logic				i_slv_sda,	// Slave SDA drive
	input  i2c_route_pkg::pin_pair_t	i_mcu_drv,	// MCU SDA/SCL drive
	input  i2c_route_pkg::pin_pair_t	i_pin,		// Pin levels
	output i2c_route_pkg::pin_pair_t	o_pin,		// Pin drive
	output i2c_route_pkg::pin_pair_t	o_slv_in,	// Slave contribution
	output i2c_route_pkg::pin_pair_t	o_mcu_in	// MCU contribution
);

	i2c_route_pkg::pin_pair_t drv;		// Combined drive, master side
	i2c_route_pkg::pin_pair_t pin_in;	// Pin levels, master side

	// ------------------------------------------------------------------------
	// Open-drain drive of both masters
	// ------------------------------------------------------------------------
	always_comb begin
		drv.sda = ~(i_sel.slv & ~i_slv_sda | i_sel.mcu & ~i_mcu_drv.sda);
		drv.scl = ~(i_sel.slv & i_stretch | i_sel.mcu & ~i_mcu_drv.scl);
	end

	// Swap toward the pins
	always_comb begin
		if (i_sel.swap) begin
			o_pin.sda = drv.scl;
			o_pin.scl = drv.sda;
		end else begin
			o_pin = drv;
		end
	end

	// ------------------------------------------------------------------------
	// Input direction
	// ------------------------------------------------------------------------
	always_comb begin
		if (i_sel.swap) begin
			pin_in.sda = i_pin.scl;
			pin_in.scl = i_pin.sda;
		end else begin
			pin_in = i_pin;
		end
	end

	// Unselected master sees released lines from this port
	always_comb begin
		o_slv_in = 2'b11;
		o_mcu_in = 2'b11;
		if (i_sel.slv) begin
			o_slv_in = pin_in;
		end
		if (i_sel.mcu) begin
			o_mcu_in = pin_in;
		end
	end

endmodule // i2c_pad_port

//--- logic/i2c_route_ctl.sv
`include "i2c_route_settings.svh"

module i2c_route_ctl (
	input  logic				i_clk,
	input  logic				i_rst_n,
	input  logic				i_cfg_we,	// Route register write strobe
	input  i2c_route_pkg::route_cfg_t	i_cfg_wdat,
	input  logic				i_strtch_en,	// Stretching allowed
	input  logic				i_pgm_busy,	// Program memory busy
	input  logic				i_slv_stretch,	// Slave asks to hold SCL
	output i2c_route_pkg::port_sel_t	o_sel [`I2C_NUM_PORTS],
	output logic				o_stretch,
	output logic				o_cc_mode	// CC pins carry I2C
);

	i2c_route_pkg::route_cfg_t route_q;

	// ------------------------------------------------------------------------
	// Route register
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			route_q <= '0;	// Both masters on GPIO, no swap
		end else if (i_cfg_we) begin
			route_q <= i_cfg_wdat;
		end
	end

	// ------------------------------------------------------------------------
	// Per-port decode
	// ------------------------------------------------------------------------
	always_comb begin
		o_sel[`I2C_PORT_GPIO].slv  = route_q.slv_route == i2c_route_pkg::ROUTE_GPIO;
		o_sel[`I2C_PORT_GPIO].mcu  = route_q.mcu_route == i2c_route_pkg::ROUTE_GPIO;
		o_sel[`I2C_PORT_GPIO].swap = 1'b0;	// Not swappable

		o_sel[`I2C_PORT_CC].slv  = route_q.slv_route == i2c_route_pkg::ROUTE_CC;
		o_sel[`I2C_PORT_CC].mcu  = route_q.mcu_route == i2c_route_pkg::ROUTE_CC;
		o_sel[`I2C_PORT_CC].swap = route_q.cc_swap;

		o_sel[`I2C_PORT_DPDM].slv  = route_q.slv_route == i2c_route_pkg::ROUTE_DPDM;
		o_sel[`I2C_PORT_DPDM].mcu  = route_q.mcu_route == i2c_route_pkg::ROUTE_DPDM;
		o_sel[`I2C_PORT_DPDM].swap = route_q.dpdm_swap;
	end

	// Slave SCL held low only while stretching is enabled
	assign o_stretch = i_strtch_en & (i_pgm_busy | i_slv_stretch);

	// PD receiver ignores CC while either master sits there
	assign o_cc_mode = o_sel[`I2C_PORT_CC].slv | o_sel[`I2C_PORT_CC].mcu;

endmodule // i2c_route_ctl

//--- logic/i2c_route_top.sv
`include "i2c_route_settings.svh"

module i2c_route_top (
	input  logic				i_clk,
	input  logic				i_rst_n,
	input  logic				i_cfg_we,
	input  i2c_route_pkg::route_cfg_t	i_cfg_wdat,
	input  logic				i_strtch_en,
	input  logic				i_pgm_busy,
	input  logic				i_slv_stretch,
	input  logic				i_slv_sda,	// Slave engine SDA out
	input  i2c_route_pkg::pin_pair_t	i_mcu_drv,	// MCU SDA/SCL out
	input  i2c_route_pkg::pad_bus_t	i_pins,		// GPIO, CC, DPDM levels
	output i2c_route_pkg::pad_bus_t	o_pins,
	output i2c_route_pkg::pin_pair_t	o_slv_in,
	output i2c_route_pkg::pin_pair_t	o_mcu_in,
	output logic				o_cc_i2c_mode	// To PD receiver
);

	i2c_route_pkg::port_sel_t	sel [`I2C_NUM_PORTS];
	i2c_route_pkg::pad_bus_t	slv_part;	// Slave contributions
	i2c_route_pkg::pad_bus_t	mcu_part;	// MCU contributions
	logic				stretch;

	// ------------------------------------------------------------------------
	// Route register and decode
	// ------------------------------------------------------------------------
	i2c_route_ctl u0_route_ctl (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_cfg_we	(i_cfg_we),
		.i_cfg_wdat	(i_cfg_wdat),
		.i_strtch_en	(i_strtch_en),
		.i_pgm_busy	(i_pgm_busy),
		.i_slv_stretch	(i_slv_stretch),
		.o_sel		(sel),
		.o_stretch	(stretch),
		.o_cc_mode	(o_cc_i2c_mode)
	); // u0_route_ctl

	// ------------------------------------------------------------------------
	// One pad port per pin pair
	// ------------------------------------------------------------------------
	for (genvar p = 0; p < `I2C_NUM_PORTS; p++) begin : g_port
		i2c_pad_port u0_pad_port (
			.i_sel		(sel[p]),
			.i_stretch	(stretch),
			.i_slv_sda	(i_slv_sda),
			.i_mcu_drv	(i_mcu_drv),
			.i_pin		(i_pins[p]),
			.o_pin		(o_pins[p]),
			.o_slv_in	(slv_part[p]),
			.o_mcu_in	(mcu_part[p])
		); // u0_pad_port
	end

	// Master inputs
	i2c_in_merge u0_in_merge (
		.i_slv_in	(slv_part),
		.i_mcu_in	(mcu_part),
		.o_slv_in	(o_slv_in),
		.o_mcu_in	(o_mcu_in)
	); // u0_in_merge

endmodule // i2c_route_top

//--- sim.f
+incdir+common
common/i2c_route_pkg.sv
logic/i2c_route_ctl.sv
logic/i2c_pad_port.sv
logic/i2c_in_merge.sv
logic/i2c_route_top.sv
verification/i2c_route_sva.sv
verification/tb_i2c_route.sv

//--- verification/i2c_route_sva.sv
`include "i2c_route_settings.svh"

module i2c_route_sva (
	input  logic				i_clk,
	input  logic				i_rst_n,
	input  i2c_route_pkg::port_sel_t	i_sel [`I2C_NUM_PORTS],	// Decoded routing
	input  i2c_route_pkg::pad_bus_t	i_pins,		// Pin levels in
	input  i2c_route_pkg::pad_bus_t	i_pins_drv,	// Pin drive out
	input  i2c_route_pkg::pin_pair_t	i_slv_in,
	input  i2c_route_pkg::pin_pair_t	i_mcu_in,
	input  logic				i_cc_mode
);

	logic slv_pins_high;	// All slave pins released
	logic mcu_pins_high;

	always_comb begin
		slv_pins_high = 1'b1;
		mcu_pins_high = 1'b1;
		for (int p = 0; p < `I2C_NUM_PORTS; p++) begin
			if (i_sel[p].slv && i_pins[p] != 2'b11) begin
				slv_pins_high = 1'b0;
			end
			if (i_sel[p].mcu && i_pins[p] != 2'b11) begin
				mcu_pins_high = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Properties
	// ------------------------------------------------------------------------
	a_cc_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_cc_mode)
		else $error("CC mode flag set in the cycle after reset");

	for (genvar p = 0; p < `I2C_NUM_PORTS; p++) begin : g_idle
		a_idle_released: assert property (@(posedge i_clk) disable iff (!i_rst_n)
			!(i_sel[p].slv || i_sel[p].mcu) |-> i_pins_drv[p] == 2'b11)
			else $error("port %0d pulls a pin low with no master routed", p);
	end

	a_slv_in_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		slv_pins_high |-> i_slv_in == 2'b11)
		else $error("slave input low while its pins are released");

	a_mcu_in_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		mcu_pins_high |-> i_mcu_in == 2'b11)
		else $error("MCU input low while its pins are released");

endmodule // i2c_route_sva

bind i2c_route_top i2c_route_sva u0_sva (
	.i_clk		(i_clk),
	.i_rst_n	(i_rst_n),
	.i_sel		(sel),
	.i_pins		(i_pins),
	.i_pins_drv	(o_pins),
	.i_slv_in	(o_slv_in),
	.i_mcu_in	(o_mcu_in),
	.i_cc_mode	(o_cc_i2c_mode)
);

//--- verification/tb_i2c_route.sv
`include "i2c_route_settings.svh"

module tb_i2c_route;

	localparam int NUM_STEPS  = 14;
	localparam int MAX_CYCLES = 10 + 4 * NUM_STEPS + 20;

	// One table row with pin vectors packed as {dpdm, cc, gpio}
	typedef struct packed {
		logic		we;		// Write the route register first
		logic [5:0]	cfg;		// Route register value
		logic [2:0]	strtch;		// {strtch_en, pgm_busy, slv_stretch}
		logic		slv_sda;
		logic [1:0]	mcu_drv;	// {sda, scl}
		logic [5:0]	pins;		// Pin input levels
		logic [5:0]	exp_pins;
		logic [1:0]	exp_slv;
		logic [1:0]	exp_mcu;
		logic		exp_cc;
	} step_t;

	logic				clk = 1'b0;
	logic				rst_n;
	logic				cfg_we;
	i2c_route_pkg::route_cfg_t	cfg_wdat;
	logic				strtch_en;
	logic				pgm_busy;
	logic				slv_stretch;
	logic				slv_sda;
	i2c_route_pkg::pin_pair_t	mcu_drv;
	i2c_route_pkg::pad_bus_t	pins_in;
	i2c_route_pkg::pad_bus_t	pins_out;
	i2c_route_pkg::pin_pair_t	slv_in;
	i2c_route_pkg::pin_pair_t	mcu_in;
	logic				cc_mode;
	step_t				steps [NUM_STEPS];
	int				cycles = 0;

	i2c_route_top i_dut (
		.i_clk		(clk),
		.i_rst_n	(rst_n),
		.i_cfg_we	(cfg_we),
		.i_cfg_wdat	(cfg_wdat),
		.i_strtch_en	(strtch_en),
		.i_pgm_busy	(pgm_busy),
		.i_slv_stretch	(slv_stretch),
		.i_slv_sda	(slv_sda),
		.i_mcu_drv	(mcu_drv),
		.i_pins		(pins_in),
		.o_pins		(pins_out),
		.o_slv_in	(slv_in),
		.o_mcu_in	(mcu_in),
		.o_cc_i2c_mode	(cc_mode)
	);

	always #4 clk = ~clk;	// 8 unit period

	// ------------------------------------------------------------------------
	// Run limit
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			abort_run($sformatf("timeout: no end of test after %0d cycles", cycles));
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic i2c_route_pkg::pad_bus_t to_pads(input logic [5:0] v);
		i2c_route_pkg::pad_bus_t pads;
		for (int p = 0; p < `I2C_NUM_PORTS; p++) begin
			pads[p] = v[2*p +: 2];
		end
		return pads;
	endfunction

	function automatic logic [5:0] from_pads(input i2c_route_pkg::pad_bus_t pads);
		logic [5:0] v;
		for (int p = 0; p < `I2C_NUM_PORTS; p++) begin
			v[2*p +: 2] = pads[p];
		end
		return v;
	endfunction

	// ------------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------------
	task automatic check_pads(input string name, input i2c_route_pkg::pad_bus_t exp,
			input i2c_route_pkg::pad_bus_t act);
		if (from_pads(act) !== from_pads(exp)) begin
			abort_run($sformatf("mismatch %s: expected %h, actual %h",
				name, from_pads(exp), from_pads(act)));
		end
	endtask

	task automatic check_pair(input string name, input i2c_route_pkg::pin_pair_t exp,
			input i2c_route_pkg::pin_pair_t act);
		if (act !== exp) begin
			abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// Strobe, then levels one cycle later, then compare
	task automatic run_step(input step_t s, input int idx);
		if (s.we) begin
			cfg_wdat = i2c_route_pkg::route_cfg_t'(s.cfg);
			cfg_we   = 1'b1;
		end
		@(negedge clk);
		cfg_we      = 1'b0;
		strtch_en   = s.strtch[2];
		pgm_busy    = s.strtch[1];
		slv_stretch = s.strtch[0];
		slv_sda     = s.slv_sda;
		mcu_drv     = s.mcu_drv;
		pins_in     = to_pads(s.pins);
		@(negedge clk);
		check_pads($sformatf("o_pins step %0d", idx), to_pads(s.exp_pins), pins_out);
		check_pair($sformatf("o_slv_in step %0d", idx), s.exp_slv, slv_in);
		check_pair($sformatf("o_mcu_in step %0d", idx), s.exp_mcu, mcu_in);
		check_bit($sformatf("o_cc_i2c_mode step %0d", idx), s.exp_cc, cc_mode);
	endtask

	// ------------------------------------------------------------------------
	// Stimulus table and main sequence
	// ------------------------------------------------------------------------
	initial begin
		rst_n       = 1'b0;
		cfg_we      = 1'b0;
		cfg_wdat    = '0;
		strtch_en   = 1'b0;
		pgm_busy    = 1'b0;
		slv_stretch = 1'b0;
		slv_sda     = 1'b1;
		mcu_drv     = 2'b11;
		pins_in     = to_pads(6'b11_11_11);

		// Reset state with both masters on GPIO
		steps[0]  = '{1'b0, 6'b00_00_00, 3'b000, 1'b0, 2'b10, 6'b10_00_01, 6'b11_11_00, 2'b01, 2'b01, 1'b0};
		steps[1]  = '{1'b0, 6'b00_00_00, 3'b000, 1'b1, 2'b11, 6'b00_00_10, 6'b11_11_11, 2'b10, 2'b10, 1'b0};
		// Slave on CC, MCU on DPDM
		steps[2]  = '{1'b1, 6'b00_10_01, 3'b000, 1'b0, 2'b10, 6'b01_10_00, 6'b10_01_11, 2'b10, 2'b01, 1'b1};
		// Swaps
		steps[3]  = '{1'b1, 6'b01_10_01, 3'b000, 1'b0, 2'b10, 6'b11_01_11, 6'b10_10_11, 2'b10, 2'b11, 1'b1};
		steps[4]  = '{1'b1, 6'b10_10_01, 3'b000, 1'b1, 2'b01, 6'b10_11_00, 6'b10_11_11, 2'b11, 2'b01, 1'b1};
		steps[5]  = '{1'b1, 6'b11_00_00, 3'b000, 1'b1, 2'b01, 6'b00_00_10, 6'b11_11_01, 2'b10, 2'b10, 1'b0};
		// Clock stretching
		steps[6]  = '{1'b1, 6'b00_11_01, 3'b011, 1'b1, 2'b00, 6'b11_11_11, 6'b11_11_11, 2'b11, 2'b11, 1'b1};
		steps[7]  = '{1'b1, 6'b00_11_01, 3'b110, 1'b1, 2'b00, 6'b11_10_11, 6'b11_10_11, 2'b10, 2'b11, 1'b1};
		steps[8]  = '{1'b1, 6'b10_11_10, 3'b101, 1'b1, 2'b00, 6'b01_11_11, 6'b01_11_11, 2'b10, 2'b11, 1'b0};
		steps[9]  = '{1'b0, 6'b10_11_10, 3'b100, 1'b1, 2'b00, 6'b11_11_11, 6'b11_11_11, 2'b11, 2'b11, 1'b0};
		// Shared port and OFF
		steps[10] = '{1'b1, 6'b00_01_01, 3'b110, 1'b1, 2'b01, 6'b00_10_00, 6'b11_00_11, 2'b10, 2'b10, 1'b1};
		steps[11] = '{1'b1, 6'b10_10_10, 3'b000, 1'b0, 2'b11, 6'b01_00_00, 6'b10_11_11, 2'b10, 2'b10, 1'b0};
		steps[12] = '{1'b1, 6'b00_01_11, 3'b110, 1'b0, 2'b10, 6'b00_01_00, 6'b11_10_11, 2'b11, 2'b01, 1'b1};
		steps[13] = '{1'b1, 6'b00_11_11, 3'b111, 1'b0, 2'b00, 6'b00_00_00, 6'b11_11_11, 2'b11, 2'b11, 1'b0};

		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < NUM_STEPS; i++) begin
			run_step(steps[i], i);
		end

		$display("Test OK");
		$finish;
	end

endmodule // tb_i2c_route
